// ==== Makefile ====
# Verilator build and run of the cpu bus testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -f sources.f --top-module tb_cpu_bus -Mdir obj_dir
	./obj_dir/Vtb_cpu_bus 2>&1 | tee $(LOG)
	grep -qx "STATUS: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== design/bus_master.sv ====
// system bus master
// runs one memory or I/O transfer per request, with alarm timeout and reply status
`default_nettype none
`timescale 1ns/10ps

`include "cpu_bus_cfg.svh"

module bus_master import bus_pkg::*; (
	input logic __clk,
	input logic reset,

	bus_req_if.slave req_bus, // from the request queue

	// system bus, all active low
	output logic [15:0] dad_,
	output logic [15:0] ddt_,
	output logic dr_,
	output logic dw_,
	output logic din_,
	input logic [15:0] rdt_,
	input logic rok_,
	input logic ren_,
	input logic rpe_,

	// transfer result
	output logic [15:0] w,
	output bus_status_t reply,
	output logic done,
	output logic awaria_
);

	localparam int ALARM_TICKS = `ALARM_DLY_TICKS;
	localparam int CNT_W = $clog2(ALARM_TICKS);

	typedef enum logic [1:0] {
		s_idle,
		s_strobe, // strobe out, waiting for a reply
		s_release // waiting for reply lines to go high
	} state_t;

	state_t state;
	logic [CNT_W-1:0] alarm_cnt;
	bus_word_t addr;
	logic start;
	logic any_reply;
	logic alarm_hit;
	logic io_refuse;
	logic mem_refuse;
	logic is_read;
	bus_status_t line_status;

	assign addr = req_bus.req.addr;
	assign is_read = req_bus.req.op == read;
	assign start = state == s_idle && req_bus.cyc && req_bus.stb && !req_bus.ack;
	assign any_reply = !rok_ || !ren_ || !rpe_;
	assign alarm_hit = alarm_cnt == CNT_W'(ALARM_TICKS - 1);

	// ------------------------------------------------------------
	// refusal before the bus
	// ------------------------------------------------------------

	assign io_refuse = req_bus.req.io && (int'(addr.io.chan) >= `IO_CHANNELS);
	assign mem_refuse = !req_bus.req.io && !is_read && addr.mem.page == 4'd0
		&& (`LOW_MEM_WRITE_DENY != 0);

	// parity error outranks engaged, engaged outranks ok
	always_comb begin
		if (!rpe_) begin
			line_status = st_pe;
		end else if (!ren_) begin
			line_status = st_en;
		end else begin
			line_status = st_ok;
		end
	end

	// ------------------------------------------------------------
	// transfer FSM
	// ------------------------------------------------------------

	always_ff @(posedge __clk) begin
		if (reset) begin
			state <= s_idle;
			alarm_cnt <= '0;
			dad_ <= '1;
			ddt_ <= '1;
			dr_ <= 1'b1;
			dw_ <= 1'b1;
			din_ <= 1'b1;
			reply <= st_ok;
			done <= 1'b0;
			req_bus.ack <= 1'b0;
			awaria_ <= 1'b1;
		end else begin
			done <= 1'b0;
			req_bus.ack <= 1'b0;
			case (state)
				s_idle: begin
					if (start && (io_refuse || mem_refuse)) begin
						reply <= io_refuse ? st_none : st_deny; // no strobe at all
						done <= 1'b1;
						req_bus.ack <= 1'b1;
					end else if (start) begin
						dad_ <= ~addr;
						ddt_ <= is_read ? '1 : ~req_bus.req.data;
						din_ <= !req_bus.req.io;
						dr_ <= !(!req_bus.req.io && is_read);
						dw_ <= !(!req_bus.req.io && !is_read);
						alarm_cnt <= '0;
						state <= s_strobe;
					end
				end
				s_strobe: begin
					if (any_reply || alarm_hit) begin
						dad_ <= '1;
						ddt_ <= '1;
						dr_ <= 1'b1;
						dw_ <= 1'b1;
						din_ <= 1'b1;
						done <= 1'b1;
						req_bus.ack <= 1'b1;
						alarm_cnt <= '0;
						state <= s_release;
						if (any_reply) begin
							reply <= line_status;
						end else begin
							reply <= st_none;
							// missing memory stops the machine
							if (!req_bus.req.io && (`STOP_ON_NOMEM != 0)) begin
								awaria_ <= 1'b0;
							end
						end
					end else begin
						alarm_cnt <= alarm_cnt + 1'b1;
					end
				end
				s_release: begin
					// a stuck reply line gives up after the same limit
					if (!any_reply || alarm_hit) begin
						state <= s_idle;
					end else begin
						alarm_cnt <= alarm_cnt + 1'b1;
					end
				end
				default: state <= s_idle;
			endcase
		end
	end

	// read data, only on a good read
	always_ff @(posedge __clk) begin
		if (state == s_strobe && any_reply && line_status == st_ok && is_read) begin
			w <= ~rdt_;
		end
	end

endmodule

`default_nettype wire

// ==== design/bus_pkg.sv ====
// bus types shared by the panel, request queue and bus master
// address word views, request record and reply status
`default_nettype none

package bus_pkg;

	// address word seen as memory address
	typedef struct packed {
		logic [3:0] page;
		logic [11:0] offset;
	} mem_addr_t;

	// address word seen as I/O address
	typedef struct packed {
		logic dir; // direction hint
		logic [3:0] chan;
		logic [2:0] dev;
		logic [7:0] regno;
	} io_addr_t;

	// one bus address word, two decodings
	typedef union packed {
		mem_addr_t mem;
		io_addr_t io;
	} bus_word_t;

	typedef enum logic {
		read = 1'b0,
		write = 1'b1
	} bus_op_t;

	// one queued bus request, 34 bits
	typedef struct packed {
		bus_op_t op;
		logic io; // I/O instead of memory
		bus_word_t addr;
		logic [15:0] data; // write data
	} bus_req_t;

	typedef enum logic [2:0] {
		st_ok,
		st_en, // device engaged
		st_pe, // parity error
		st_none, // no answer
		st_deny // refused before the bus
	} bus_status_t;

endpackage

`default_nettype wire

// ==== design/bus_req_if.sv ====
// request link between design blocks
// Wishbone classic handshake carrying one bus request per ack
`default_nettype none
`timescale 1ns/10ps

interface bus_req_if import bus_pkg::*; ();

	logic cyc;
	logic stb;
	logic ack; // one cycle per transferred request
	bus_req_t req;

	// request source
	modport master(
		output cyc,
		output stb,
		output req,
		input ack
	);

	// request sink
	modport slave(
		input cyc,
		input stb,
		input req,
		output ack
	);

endinterface

`default_nettype wire

// ==== design/cpu_bus.sv ====
// cpu system bus access path
// panel commands, request queue and bus master behind plain panel and bus ports
`default_nettype none
`timescale 1ns/10ps

`include "cpu_bus_cfg.svh"

module cpu_bus import bus_pkg::*; (
	// control panel
	input logic [15:0] kl,
	input logic panel_load_,
	input logic panel_store_,
	input logic panel_fetch_,
	input logic inou,
	output logic wait_,
	output logic [15:0] w,
	output bus_status_t reply,
	output logic done,
	output logic awaria_,

	// system bus
	output logic [15:0] dad_,
	output logic [15:0] ddt_,
	output logic dr_,
	output logic dw_,
	output logic din_,
	input logic [15:0] rdt_,
	input logic rok_,
	input logic ren_,
	input logic rpe_,

	input logic reset,
	input logic __clk
);

	bus_req_if link_a(); // panel -> queue
	bus_req_if link_b(); // queue -> bus master

	// ------------------------------------------------------------
	// panel commands
	// ------------------------------------------------------------

	panel_cmd PNL(
		.__clk(__clk),
		.reset(reset),
		.kl(kl),
		.panel_load_(panel_load_),
		.panel_store_(panel_store_),
		.panel_fetch_(panel_fetch_),
		.inou(inou),
		.wait_(wait_),
		.req_bus(link_a)
	);

	// ------------------------------------------------------------
	// request queue
	// ------------------------------------------------------------

	req_fifo #(
		.DEPTH(`REQ_FIFO_DEPTH)
	) RQF(
		.__clk(__clk),
		.reset(reset),
		.push(link_a),
		.pop(link_b)
	);

	// ------------------------------------------------------------
	// bus master
	// ------------------------------------------------------------

	bus_master BUS(
		.__clk(__clk),
		.reset(reset),
		.req_bus(link_b),
		.dad_(dad_),
		.ddt_(ddt_),
		.dr_(dr_),
		.dw_(dw_),
		.din_(din_),
		.rdt_(rdt_),
		.rok_(rok_),
		.ren_(ren_),
		.rpe_(rpe_),
		.w(w),
		.reply(reply),
		.done(done),
		.awaria_(awaria_)
	);

endmodule

`default_nettype wire

// ==== design/cpu_bus_cfg.svh ====
// cpu bus path configuration
// bus timing, request queue depth and CPU feature switches
`ifndef CPU_BUS_CFG_SVH
`define CPU_BUS_CFG_SVH

// ------------------------------------------------------------
// bus timing
// ------------------------------------------------------------

// clock cycles to wait for rok_/ren_/rpe_ before no answer
`define ALARM_DLY_TICKS 250

// ------------------------------------------------------------
// request queue
// ------------------------------------------------------------

`define REQ_FIFO_DEPTH 4 // power of two

// ------------------------------------------------------------
// cpu features
// ------------------------------------------------------------

`define IO_CHANNELS 8 // fitted I/O channels
`define LOW_MEM_WRITE_DENY 1 // refuse memory writes to page 0
`define STOP_ON_NOMEM 1 // memory no-answer latches awaria_

`endif

// ==== design/panel_cmd.sv ====
// control panel command unit
// turns panel key strobes into bus requests, keeps the panel address register
`default_nettype none
`timescale 1ns/10ps

module panel_cmd import bus_pkg::*; (
	input logic __clk,
	input logic reset,

	// control panel
	input logic [15:0] kl,
	input logic panel_load_,
	input logic panel_store_,
	input logic panel_fetch_,
	input logic inou, // I/O instead of memory
	output logic wait_,

	// link to the request queue
	bus_req_if.master req_bus
);

	logic busy; // request waiting for ack
	logic take; // store or fetch accepted this edge
	logic [15:0] ar; // panel address register
	bus_req_t req_q;

	// load has priority over store and fetch
	assign take = !busy && panel_load_ && (!panel_store_ || !panel_fetch_);

	// ------------------------------------------------------------
	// control
	// ------------------------------------------------------------

	always_ff @(posedge __clk) begin
		if (reset) begin
			busy <= 1'b0;
			ar <= '0;
		end else if (busy) begin
			if (req_bus.ack) begin
				busy <= 1'b0;
				// I/O leaves the address alone
				if (!req_q.io) begin
					ar <= ar + 16'd1;
				end
			end
		end else if (!panel_load_) begin
			ar <= kl;
		end else if (take) begin
			busy <= 1'b1;
		end
	end

	// ------------------------------------------------------------
	// request word
	// ------------------------------------------------------------

	always_ff @(posedge __clk) begin
		if (take) begin
			req_q.op <= !panel_store_ ? write : read; // store wins over fetch
			req_q.io <= inou;
			req_q.addr <= ar;
			req_q.data <= kl;
		end
	end

	// request held until the queue acks it
	assign req_bus.cyc = busy;
	assign req_bus.stb = busy;
	assign req_bus.req = req_q;

	assign wait_ = !busy; // panel locked out while a request is pending

endmodule

`default_nettype wire

// ==== design/req_fifo.sv ====
// bus request queue
// circular buffer between the panel link and the bus master link
`default_nettype none
`timescale 1ns/10ps

`include "cpu_bus_cfg.svh"

module req_fifo import bus_pkg::*; #(
	parameter int DEPTH = `REQ_FIFO_DEPTH
) (
	input logic __clk,
	input logic reset,
	bus_req_if.slave push, // from the panel
	bus_req_if.master pop // to the bus master
);

	localparam int PTR_W = $clog2(DEPTH);

	bus_req_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0] count; // occupancy
	logic full;
	logic empty;
	logic push_fire;
	logic pop_fire;
	logic out_stb;

	assign full = count == (PTR_W + 1)'(DEPTH);
	assign empty = count == '0;
	assign push_fire = push.cyc && push.stb && push.ack;
	assign pop_fire = out_stb && pop.ack;

	// ------------------------------------------------------------
	// input side
	// ------------------------------------------------------------

	// ack one cycle after stb, held back while full
	always_ff @(posedge __clk) begin
		if (reset) begin
			push.ack <= 1'b0;
		end else begin
			push.ack <= push.cyc && push.stb && !push.ack && !full;
		end
	end

	always_ff @(posedge __clk) begin
		if (push_fire) begin
			mem[wr_ptr] <= push.req;
		end
	end

	// ------------------------------------------------------------
	// pointers and count
	// ------------------------------------------------------------

	always_ff @(posedge __clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push_fire) wr_ptr <= wr_ptr + 1'b1; // wraps, depth is 2^n
			if (pop_fire) rd_ptr <= rd_ptr + 1'b1;
			case ({push_fire, pop_fire})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ; // both or neither
			endcase
		end
	end

	// ------------------------------------------------------------
	// output side
	// ------------------------------------------------------------

	// stb drops for a cycle after each ack
	always_ff @(posedge __clk) begin
		if (reset) begin
			out_stb <= 1'b0;
		end else if (pop.ack) begin
			out_stb <= 1'b0;
		end else if (!empty) begin
			out_stb <= 1'b1;
		end
	end

	assign pop.cyc = out_stb;
	assign pop.stb = out_stb;
	assign pop.req = mem[rd_ptr]; // head entry

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+design
design/bus_pkg.sv
design/bus_req_if.sv
design/panel_cmd.sv
design/req_fifo.sv
design/bus_master.sv
design/cpu_bus.sv
testbench/tb_bus_responder.sv
testbench/tb_cpu_bus.sv

// ==== testbench/tb_bus_responder.sv ====
// system bus device model for the testbench
// memory on pages 1 to 7 and I/O devices, replying after random delays
`default_nettype none
`timescale 1ns/10ps

module tb_bus_responder (
	input logic clk,
	input logic reset,
	input logic [15:0] dad_,
	input logic [15:0] ddt_,
	input logic dr_,
	input logic dw_,
	input logic din_,
	input logic slow, // stretch reply delay
	output logic [15:0] rdt_,
	output logic rok_,
	output logic ren_,
	output logic rpe_,
	output int strobe_count
);

	typedef enum logic [1:0] {r_idle, r_delay, r_hold} rsp_state_t;
	typedef enum logic [1:0] {a_ok, a_en, a_pe, a_none} answer_t;

	rsp_state_t state = r_idle;
	answer_t answer = a_none;
	int delay_left = 0;
	int count_q = 0;
	logic [15:0] data_q = '0; // word returned on rdt_
	logic [15:0] rdt_q = '1;
	logic ok_q = 1'b1;
	logic en_q = 1'b1;
	logic pe_q = 1'b1;
	logic strobe;
	logic [15:0] mem [logic [15:0]]; // sparse, full address index

	assign strobe = !dr_ || !dw_ || !din_;
	assign rdt_ = rdt_q;
	assign rok_ = ok_q;
	assign ren_ = en_q;
	assign rpe_ = pe_q;
	assign strobe_count = count_q;

	function automatic logic [15:0] fill_word(input logic [15:0] a);
		return {a[7:0], a[15:8]} ^ 16'h3c5a;
	endfunction

	always @(posedge clk) begin
		logic [15:0] a;
		if (reset) begin
			state <= r_idle;
			count_q <= 0;
			rdt_q <= '1;
			ok_q <= 1'b1;
			en_q <= 1'b1;
			pe_q <= 1'b1;
		end else begin
			case (state)
				r_idle: begin
					if (strobe) begin
						a = ~dad_;
						count_q <= count_q + 1;
						delay_left <= $urandom_range(6, 1) + (slow ? 30 : 0);
						state <= r_delay;
						data_q <= a; // I/O returns the address word
						if (!din_) begin
							answer <= (a[10:8] == 3'd7) ? a_en : a_ok;
						end else if (a[11:0] == 12'hbad) begin
							answer <= a_pe;
						end else if (a[15:12] >= 4'd1 && a[15:12] <= 4'd7) begin
							answer <= a_ok;
							if (!dw_) begin
								mem[a] = ~ddt_;
							end else begin
								data_q <= mem.exists(a) ? mem[a] : fill_word(a);
							end
						end else begin
							answer <= a_none;
							state <= r_hold; // silent until released
						end
					end
				end
				r_delay: begin
					if (delay_left <= 1) begin
						rdt_q <= ~data_q;
						ok_q <= answer != a_ok;
						en_q <= answer != a_en;
						pe_q <= answer != a_pe;
						state <= r_hold;
					end else begin
						delay_left <= delay_left - 1;
					end
				end
				default: begin
					// reply held until the strobe goes away
					if (!strobe) begin
						rdt_q <= '1;
						ok_q <= 1'b1;
						en_q <= 1'b1;
						pe_q <= 1'b1;
						state <= r_idle;
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== testbench/tb_cpu_bus.sv ====
// testbench for the cpu system bus access path
// random panel strobes checked against a reference model of the request path
`default_nettype none
`timescale 1ns/10ps

`include "cpu_bus_cfg.svh"

module tb_cpu_bus import bus_pkg::*; ();

	localparam int WAIT_LIMIT = 4000; // cycles per wait
	localparam int N_RANDOM = 80;
	localparam int N_BURST = 16;
	localparam logic [1:0] K_LOAD = 2'd0;
	localparam logic [1:0] K_STORE = 2'd1;
	localparam logic [1:0] K_FETCH = 2'd2;

	// expected outcome of one accepted request
	typedef struct packed {
		bus_status_t st;
		logic chk_w; // read data to compare
		logic [15:0] word;
		logic [31:0] strobes; // strobes seen once this request is done
		logic alarm_; // awaria_ after this request
	} exp_t;

	logic clk;
	logic reset;
	logic [15:0] kl;
	logic panel_load_;
	logic panel_store_;
	logic panel_fetch_;
	logic inou;
	logic wait_;
	logic [15:0] w;
	bus_status_t reply;
	logic done;
	logic awaria_;
	logic [15:0] dad_;
	logic [15:0] ddt_;
	logic dr_;
	logic dw_;
	logic din_;
	logic [15:0] rdt_;
	logic rok_;
	logic ren_;
	logic rpe_;
	logic slow;
	int strobe_count;

	// reference model state
	exp_t exp_q[$];
	int done_idx; // results checked so far
	logic [15:0] mem_m [logic [15:0]]; // words written to fitted memory
	logic [15:0] ar_m;
	logic [31:0] strobes_m;
	logic alarm_m;
	int taken; // store and fetch strobes accepted by the panel

	cpu_bus UUT(
		.kl(kl),
		.panel_load_(panel_load_),
		.panel_store_(panel_store_),
		.panel_fetch_(panel_fetch_),
		.inou(inou),
		.wait_(wait_),
		.w(w),
		.reply(reply),
		.done(done),
		.awaria_(awaria_),
		.dad_(dad_),
		.ddt_(ddt_),
		.dr_(dr_),
		.dw_(dw_),
		.din_(din_),
		.rdt_(rdt_),
		.rok_(rok_),
		.ren_(ren_),
		.rpe_(rpe_),
		.reset(reset),
		.__clk(clk)
	);

	tb_bus_responder RSP(
		.clk(clk),
		.reset(reset),
		.dad_(dad_),
		.ddt_(ddt_),
		.dr_(dr_),
		.dw_(dw_),
		.din_(din_),
		.slow(slow),
		.rdt_(rdt_),
		.rok_(rok_),
		.ren_(ren_),
		.rpe_(rpe_),
		.strobe_count(strobe_count)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ------------------------------------------------------------
	// failure reporting and compare tasks
	// ------------------------------------------------------------

	task automatic abort_run();
		$display("STATUS: FAIL");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check_reply(input bus_status_t got, input bus_status_t exp);
		if (got !== exp) begin
			$display("** Error at %0t: reply %s, expected %s", $time, got.name(), exp.name());
			abort_run();
		end
	endtask

	task automatic check_word(input logic [15:0] got, input logic [15:0] exp);
		if (got !== exp) begin
			$display("** Error at %0t: read word %h, expected %h", $time, got, exp);
			abort_run();
		end
	endtask

	task automatic check_count(input int got, input int exp);
		if (got != exp) begin
			$display("** Error at %0t: %0d bus strobes, expected %0d", $time, got, exp);
			abort_run();
		end
	endtask

	task automatic check_alarm(input logic got, input logic exp);
		if (got !== exp) begin
			$display("** Error at %0t: awaria_ %b, expected %b", $time, got, exp);
			abort_run();
		end
	endtask

	// ------------------------------------------------------------
	// reference model
	// ------------------------------------------------------------

	// contents of never written memory
	function automatic logic [15:0] fill_word(input logic [15:0] a);
		return {a[7:0], a[15:8]} ^ 16'h3c5a;
	endfunction

	function automatic void model_request(input logic is_write, input logic io,
		input logic [15:0] a, input logic [15:0] data);
		exp_t e;
		e.chk_w = 1'b0;
		e.word = '0;
		if (io) begin
			if (int'(a[14:11]) >= `IO_CHANNELS) begin
				e.st = st_none; // channel not fitted, no strobe
			end else begin
				strobes_m++;
				if (a[10:8] == 3'd7) begin
					e.st = st_en;
				end else begin
					e.st = st_ok;
					e.chk_w = !is_write;
					e.word = a;
				end
			end
		end else if (is_write && a[15:12] == 4'd0 && `LOW_MEM_WRITE_DENY != 0) begin
			e.st = st_deny;
		end else begin
			strobes_m++;
			if (a[11:0] == 12'hbad) begin
				e.st = st_pe;
			end else if (a[15:12] >= 4'd1 && a[15:12] <= 4'd7) begin
				e.st = st_ok;
				if (is_write) begin
					mem_m[a] = data;
				end else begin
					e.chk_w = 1'b1;
					e.word = mem_m.exists(a) ? mem_m[a] : fill_word(a);
				end
			end else begin
				e.st = st_none; // memory not fitted
				if (`STOP_ON_NOMEM != 0) begin
					alarm_m = 1'b0;
				end
			end
		end
		e.strobes = strobes_m;
		e.alarm_ = alarm_m;
		exp_q.push_back(e);
	endfunction

	// ------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------

	// one strobe pulse, sampled by the DUT on the following edge
	task automatic strobe_panel(input logic [1:0] kind, input logic [15:0] key,
		input logic io);
		@(posedge clk);
		kl <= key;
		inou <= io;
		case (kind)
			K_LOAD: panel_load_ <= 1'b0;
			K_STORE: panel_store_ <= 1'b0;
			default: panel_fetch_ <= 1'b0;
		endcase
		@(negedge clk);
		if (wait_) begin
			if (kind == K_LOAD) begin
				ar_m = key;
			end else begin
				taken++;
				model_request(kind == K_STORE, io, ar_m, key);
				if (!io) begin
					ar_m = ar_m + 16'd1;
				end
			end
		end
		@(posedge clk);
		panel_load_ <= 1'b1;
		panel_store_ <= 1'b1;
		panel_fetch_ <= 1'b1;
	endtask

	task automatic wait_panel_ready();
		int n;
		n = 0;
		@(negedge clk);
		while (!wait_) begin
			n++;
			if (n > WAIT_LIMIT) begin
				$display("timeout: panel wait_ stayed low");
				abort_run();
			end
			@(negedge clk);
		end
	endtask

	task automatic issue_op(input logic [1:0] kind, input logic [15:0] key, input logic io);
		wait_panel_ready();
		strobe_panel(kind, key, io);
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while (done_idx != exp_q.size()) begin
			@(negedge clk);
			n++;
			if (n > WAIT_LIMIT) begin
				$display("timeout: accepted requests never completed");
				abort_run();
			end
		end
	endtask

	// mostly fitted pages and a few offsets, so reads meet earlier writes
	function automatic logic [15:0] random_addr();
		int r;
		logic [3:0] pg;
		logic [11:0] off;
		r = $urandom_range(15, 0);
		pg = r[3:0];
		if ($urandom_range(3, 0) != 0) begin
			r = $urandom_range(7, 1);
			pg = r[3:0];
		end
		r = $urandom_range(15, 0);
		off = {8'h00, r[3:0]};
		if ($urandom_range(7, 0) == 0) begin
			off = 12'hbad;
		end
		return {pg, off};
	endfunction

	function automatic logic [15:0] random_word();
		int r;
		r = $urandom;
		return r[15:0];
	endfunction

	// ------------------------------------------------------------
	// result monitor
	// ------------------------------------------------------------

	always @(negedge clk) begin : result_monitor
		exp_t e;
		if (!reset && done) begin
			if (done_idx >= exp_q.size()) begin
				$display("done pulse at %0t with no request outstanding", $time);
				abort_run();
			end
			e = exp_q[done_idx];
			check_reply(reply, e.st);
			if (e.chk_w) begin
				check_word(w, e.word);
			end
			check_count(strobe_count, int'(e.strobes));
			check_alarm(awaria_, e.alarm_);
			done_idx <= done_idx + 1;
		end
	end

	initial begin
		int r;
		void'($urandom(32'h488dfecd));
		reset = 1'b1;
		kl = '0;
		panel_load_ = 1'b1;
		panel_store_ = 1'b1;
		panel_fetch_ = 1'b1;
		inou = 1'b0;
		slow = 1'b0;
		done_idx = 0;
		ar_m = '0;
		strobes_m = '0;
		alarm_m = 1'b1;
		taken = 0;
		repeat (2) @(posedge clk);
		reset <= 1'b0;

		// write and read back, address steps after each memory access
		issue_op(K_LOAD, 16'h1234, 1'b0);
		issue_op(K_STORE, 16'hbeef, 1'b0);
		issue_op(K_STORE, 16'h0101, 1'b0);
		issue_op(K_LOAD, 16'h1234, 1'b0);
		issue_op(K_FETCH, 16'h0000, 1'b0);
		issue_op(K_FETCH, 16'h0000, 1'b0);
		// low page write refused
		issue_op(K_LOAD, 16'h0040, 1'b0);
		issue_op(K_STORE, 16'h5555, 1'b0);
		// I/O: missing channel, engaged device 7, plain read
		issue_op(K_LOAD, 16'h4000, 1'b0);
		issue_op(K_FETCH, 16'h0000, 1'b1);
		issue_op(K_LOAD, 16'h0700, 1'b0);
		issue_op(K_STORE, 16'h00aa, 1'b1);
		issue_op(K_LOAD, 16'h0a21, 1'b0);
		issue_op(K_FETCH, 16'h0000, 1'b1);
		// parity error, then missing memory raises the alarm
		issue_op(K_LOAD, 16'h2bad, 1'b0);
		issue_op(K_FETCH, 16'h0000, 1'b0);
		issue_op(K_LOAD, 16'h9010, 1'b0);
		issue_op(K_FETCH, 16'h0000, 1'b0);

		for (int i = 0; i < N_RANDOM; i++) begin
			r = $urandom_range(2, 0);
			if (r[1:0] == K_LOAD) begin
				issue_op(K_LOAD, random_addr(), 1'b0);
			end else begin
				issue_op(r[1:0], random_word(), $urandom_range(3, 0) == 0);
			end
		end

		// slow replies fill the queue and lock the panel out
		wait_drain();
		@(posedge clk);
		slow <= 1'b1;
		issue_op(K_LOAD, 16'h2100, 1'b0);
		taken = 0;
		for (int i = 0; i < N_BURST; i++) begin
			r = $urandom_range(1, 0);
			strobe_panel(r[0] ? K_STORE : K_FETCH, random_word(), 1'b0);
		end
		// full queue plus the one request held in the panel
		if (taken != `REQ_FIFO_DEPTH + 1) begin
			$display("** Error at %0t: burst accepted %0d requests, expected %0d",
				$time, taken, `REQ_FIFO_DEPTH + 1);
			abort_run();
		end
		@(posedge clk);
		slow <= 1'b0;

		wait_drain();
		@(negedge clk);
		check_count(strobe_count, int'(strobes_m));
		check_alarm(awaria_, alarm_m);
		$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire
